/* Makefile */
TOP := tb_axi_crossbar

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f
	verilator --lint-only --top-module axi_crossbar design/xbar_pkg.sv \
		design/xbar_read_path.sv design/xbar_write_path.sv design/axi_crossbar.sv

clean:
	rm -rf obj_dir

/* build.f */
design/xbar_pkg.sv
design/xbar_read_path.sv
design/xbar_write_path.sv
design/axi_crossbar.sv
dv/xbar_assertions.sv
dv/tb_axi_crossbar.sv

/* design/axi_crossbar.sv */
`timescale 1ns/10ps

module axi_crossbar (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    instr_fetching_i,
    // if master, reads only
    input  logic                    if_ar_valid_i,
    input  xbar_pkg::axi_addr_req_t if_ar_i,
    output logic                    if_ar_ready_o,
    output logic                    if_r_valid_o,
    input  logic                    if_r_ready_i,
    // ls master
    input  logic                    ls_ar_valid_i,
    input  xbar_pkg::axi_addr_req_t ls_ar_i,
    output logic                    ls_ar_ready_o,
    output logic                    ls_r_valid_o,
    input  logic                    ls_r_ready_i,
    output xbar_pkg::axi_r_beat_t   r_o,                // r payload to either master
    input  logic                    ls_aw_valid_i,
    input  xbar_pkg::axi_addr_req_t ls_aw_i,
    output logic                    ls_aw_ready_o,
    input  logic                    ls_w_valid_i,
    input  xbar_pkg::axi_w_beat_t   ls_w_i,
    output logic                    ls_w_ready_o,
    output logic                    ls_b_valid_o,
    output xbar_pkg::axi_b_resp_t   ls_b_o,
    input  logic                    ls_b_ready_i,
    // slave side, read
    output logic                    mem_ar_valid_o,
    input  logic                    mem_ar_ready_i,
    output logic                    mmio_ar_valid_o,
    input  logic                    mmio_ar_ready_i,
    output xbar_pkg::axi_addr_req_t slv_ar_o,
    input  logic                    mem_r_valid_i,
    input  xbar_pkg::axi_r_beat_t   mem_r_i,
    output logic                    mem_r_ready_o,
    input  logic                    mmio_r_valid_i,
    input  xbar_pkg::axi_r_beat_t   mmio_r_i,
    output logic                    mmio_r_ready_o,
    // slave side, write
    output logic                    mem_aw_valid_o,
    input  logic                    mem_aw_ready_i,
    output logic                    mmio_aw_valid_o,
    input  logic                    mmio_aw_ready_i,
    output xbar_pkg::axi_addr_req_t slv_aw_o,
    output logic                    mem_w_valid_o,
    input  logic                    mem_w_ready_i,
    output logic                    mmio_w_valid_o,
    input  logic                    mmio_w_ready_i,
    output xbar_pkg::axi_w_beat_t   slv_w_o,
    input  logic                    mem_b_valid_i,
    input  xbar_pkg::axi_b_resp_t   mem_b_i,
    output logic                    mem_b_ready_o,
    input  logic                    mmio_b_valid_i,
    input  xbar_pkg::axi_b_resp_t   mmio_b_i,
    output logic                    mmio_b_ready_o
);

    // port names match the paths one to one
    xbar_read_path i_read_path (.*);

    xbar_write_path i_write_path (.*);

endmodule

/* design/xbar_pkg.sv */
package xbar_pkg;

    localparam int AXI_ADDR_W   = 64;
    localparam int AXI_DATA_W   = 64;
    localparam int AXI_ID_W     = 4;
    localparam int AXI_STRB_W   = AXI_DATA_W / 8;
    localparam int AXI_LEN_W    = 8;

    localparam int MMIO_SEL_BIT = 29;   // addr bit, set means mmio
    localparam int ID_LS_BIT    = 0;    // id bit, set means ls master

    typedef enum logic {
        TGT_MEM  = 1'b0,
        TGT_MMIO = 1'b1
    } target_e;

    // shared by AR and AW
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_LEN_W-1:0]  len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_addr_req_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_beat_t;

    typedef struct packed {
        logic [1:0]          resp;
        logic [AXI_ID_W-1:0] id;
    } axi_b_resp_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
        logic [AXI_ID_W-1:0]   id;
    } axi_r_beat_t;

endpackage

/* design/xbar_read_path.sv */
`timescale 1ns/10ps

module xbar_read_path (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    instr_fetching_i,   // if owns AR when high
    // masters
    input  logic                    if_ar_valid_i,
    input  xbar_pkg::axi_addr_req_t if_ar_i,
    output logic                    if_ar_ready_o,
    input  logic                    ls_ar_valid_i,
    input  xbar_pkg::axi_addr_req_t ls_ar_i,
    output logic                    ls_ar_ready_o,
    output logic                    if_r_valid_o,
    input  logic                    if_r_ready_i,
    output logic                    ls_r_valid_o,
    input  logic                    ls_r_ready_i,
    output xbar_pkg::axi_r_beat_t   r_o,                // shared by both masters
    // slaves
    output logic                    mem_ar_valid_o,
    input  logic                    mem_ar_ready_i,
    output logic                    mmio_ar_valid_o,
    input  logic                    mmio_ar_ready_i,
    output xbar_pkg::axi_addr_req_t slv_ar_o,
    input  logic                    mem_r_valid_i,
    input  xbar_pkg::axi_r_beat_t   mem_r_i,
    output logic                    mem_r_ready_o,
    input  logic                    mmio_r_valid_i,
    input  xbar_pkg::axi_r_beat_t   mmio_r_i,
    output logic                    mmio_r_ready_o
);

    xbar_pkg::axi_addr_req_t sel_ar;
    logic                    sel_ar_valid;
    xbar_pkg::target_e       ar_tgt;
    logic                    slv_ar_ready;
    logic                    ar_ready;
    logic                    ar_hs;
    logic                    rd_busy_q;
    xbar_pkg::target_e       rd_tgt_q;
    logic                    r_valid;
    logic                    r_to_ls;
    logic                    r_ready;
    logic                    r_done;

    // master select
    assign sel_ar       = instr_fetching_i ? if_ar_i       : ls_ar_i;
    assign sel_ar_valid = instr_fetching_i ? if_ar_valid_i : ls_ar_valid_i;
    assign slv_ar_o     = sel_ar;

    // target decode
    assign ar_tgt = sel_ar.addr[xbar_pkg::MMIO_SEL_BIT] ? xbar_pkg::TGT_MMIO
                                                        : xbar_pkg::TGT_MEM;

    assign mem_ar_valid_o  = sel_ar_valid & ~rd_busy_q & (ar_tgt == xbar_pkg::TGT_MEM);
    assign mmio_ar_valid_o = sel_ar_valid & ~rd_busy_q & (ar_tgt == xbar_pkg::TGT_MMIO);

    assign slv_ar_ready = (ar_tgt == xbar_pkg::TGT_MMIO) ? mmio_ar_ready_i : mem_ar_ready_i;
    assign ar_ready     = slv_ar_ready & ~rd_busy_q;   // blocked while a read is open
    assign if_ar_ready_o = instr_fetching_i & ar_ready;
    assign ls_ar_ready_o = ~instr_fetching_i & ar_ready;

    assign ar_hs = (mem_ar_valid_o & mem_ar_ready_i) | (mmio_ar_valid_o & mmio_ar_ready_i);

    // response from the latched slave only
    assign r_o     = (rd_tgt_q == xbar_pkg::TGT_MMIO) ? mmio_r_i : mem_r_i;
    assign r_valid = rd_busy_q & ((rd_tgt_q == xbar_pkg::TGT_MMIO) ? mmio_r_valid_i
                                                                   : mem_r_valid_i);
    assign r_to_ls = r_o.id[xbar_pkg::ID_LS_BIT];

    assign if_r_valid_o = r_valid & ~r_to_ls;
    assign ls_r_valid_o = r_valid & r_to_ls;
    assign r_ready      = r_to_ls ? ls_r_ready_i : if_r_ready_i;

    assign mem_r_ready_o  = rd_busy_q & (rd_tgt_q == xbar_pkg::TGT_MEM) & r_ready;
    assign mmio_r_ready_o = rd_busy_q & (rd_tgt_q == xbar_pkg::TGT_MMIO) & r_ready;

    assign r_done = r_valid & r_ready & r_o.last;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_busy_q <= 1'b0;
            rd_tgt_q  <= xbar_pkg::TGT_MEM;
        end else if (ar_hs) begin
            rd_busy_q <= 1'b1;
            rd_tgt_q  <= ar_tgt;
        end else if (r_done) begin
            rd_busy_q <= 1'b0;   // last beat taken
        end
    end

endmodule

/* design/xbar_write_path.sv */
`timescale 1ns/10ps

module xbar_write_path (
    input  logic                    clk,
    input  logic                    arst_n_i,
    // ls master
    input  logic                    ls_aw_valid_i,
    input  xbar_pkg::axi_addr_req_t ls_aw_i,
    output logic                    ls_aw_ready_o,
    input  logic                    ls_w_valid_i,
    input  xbar_pkg::axi_w_beat_t   ls_w_i,
    output logic                    ls_w_ready_o,
    output logic                    ls_b_valid_o,
    output xbar_pkg::axi_b_resp_t   ls_b_o,
    input  logic                    ls_b_ready_i,
    // slaves
    output logic                    mem_aw_valid_o,
    input  logic                    mem_aw_ready_i,
    output logic                    mmio_aw_valid_o,
    input  logic                    mmio_aw_ready_i,
    output xbar_pkg::axi_addr_req_t slv_aw_o,
    output logic                    mem_w_valid_o,
    input  logic                    mem_w_ready_i,
    output logic                    mmio_w_valid_o,
    input  logic                    mmio_w_ready_i,
    output xbar_pkg::axi_w_beat_t   slv_w_o,
    input  logic                    mem_b_valid_i,
    input  xbar_pkg::axi_b_resp_t   mem_b_i,
    output logic                    mem_b_ready_o,
    input  logic                    mmio_b_valid_i,
    input  xbar_pkg::axi_b_resp_t   mmio_b_i,
    output logic                    mmio_b_ready_o
);

    xbar_pkg::target_e aw_tgt;
    logic              aw_hs;
    logic              wr_busy_q;
    xbar_pkg::target_e wr_tgt_q;
    logic              wr_to_mem;
    logic              wr_to_mmio;
    logic              b_hs;

    assign aw_tgt = ls_aw_i.addr[xbar_pkg::MMIO_SEL_BIT] ? xbar_pkg::TGT_MMIO
                                                         : xbar_pkg::TGT_MEM;

    assign slv_aw_o        = ls_aw_i;
    assign mem_aw_valid_o  = ls_aw_valid_i & ~wr_busy_q & (aw_tgt == xbar_pkg::TGT_MEM);
    assign mmio_aw_valid_o = ls_aw_valid_i & ~wr_busy_q & (aw_tgt == xbar_pkg::TGT_MMIO);
    assign ls_aw_ready_o   = ~wr_busy_q & ((aw_tgt == xbar_pkg::TGT_MMIO) ? mmio_aw_ready_i
                                                                          : mem_aw_ready_i);

    assign aw_hs = ls_aw_valid_i & ls_aw_ready_o;

    // W and B follow the latched target
    assign wr_to_mem  = wr_busy_q & (wr_tgt_q == xbar_pkg::TGT_MEM);
    assign wr_to_mmio = wr_busy_q & (wr_tgt_q == xbar_pkg::TGT_MMIO);

    assign slv_w_o        = ls_w_i;
    assign mem_w_valid_o  = wr_to_mem & ls_w_valid_i;
    assign mmio_w_valid_o = wr_to_mmio & ls_w_valid_i;
    assign ls_w_ready_o   = (wr_to_mem & mem_w_ready_i) | (wr_to_mmio & mmio_w_ready_i);

    assign ls_b_o         = (wr_tgt_q == xbar_pkg::TGT_MMIO) ? mmio_b_i : mem_b_i;
    assign ls_b_valid_o   = (wr_to_mem & mem_b_valid_i) | (wr_to_mmio & mmio_b_valid_i);
    assign mem_b_ready_o  = wr_to_mem & ls_b_ready_i;
    assign mmio_b_ready_o = wr_to_mmio & ls_b_ready_i;

    assign b_hs = ls_b_valid_o & ls_b_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_busy_q <= 1'b0;
            wr_tgt_q  <= xbar_pkg::TGT_MEM;
        end else if (aw_hs) begin
            wr_busy_q <= 1'b1;
            wr_tgt_q  <= aw_tgt;
        end else if (b_hs) begin
            wr_busy_q <= 1'b0;   // write closed by B
        end
    end

endmodule

/* dv/tb_axi_crossbar.sv */
`timescale 1ns/10ps

module tb_axi_crossbar;

    localparam int TIMEOUT = 50;   // cycles per wait
    localparam int CH_AR = 0, CH_R = 1, CH_AW = 2, CH_W = 3, CH_B = 4;

    logic clk;
    logic arst_n_i;
    logic instr_fetching_i;
    logic if_ar_valid_i, if_ar_ready_o, if_r_valid_o, if_r_ready_i;
    logic ls_ar_valid_i, ls_ar_ready_o, ls_r_valid_o, ls_r_ready_i;
    logic ls_aw_valid_i, ls_aw_ready_o, ls_w_valid_i, ls_w_ready_o, ls_b_valid_o, ls_b_ready_i;
    logic mem_ar_valid_o, mem_ar_ready_i, mmio_ar_valid_o, mmio_ar_ready_i;
    logic mem_r_valid_i, mem_r_ready_o, mmio_r_valid_i, mmio_r_ready_o;
    logic mem_aw_valid_o, mem_aw_ready_i, mmio_aw_valid_o, mmio_aw_ready_i;
    logic mem_w_valid_o, mem_w_ready_i, mmio_w_valid_o, mmio_w_ready_i;
    logic mem_b_valid_i, mem_b_ready_o, mmio_b_valid_i, mmio_b_ready_o;
    xbar_pkg::axi_addr_req_t if_ar_i, ls_ar_i, ls_aw_i, slv_ar_o, slv_aw_o;
    xbar_pkg::axi_w_beat_t   ls_w_i, slv_w_o;
    xbar_pkg::axi_r_beat_t   r_o, mem_r_i, mmio_r_i;
    xbar_pkg::axi_b_resp_t   ls_b_o, mem_b_i, mmio_b_i;

    integer seed = 32'h802a;
    int     value_errs = 0;
    int     timeout_errs = 0;

    axi_crossbar i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive_idle();
        instr_fetching_i = 1'b0;
        if_ar_valid_i    = 1'b0;
        if_ar_i          = '0;
        ls_ar_valid_i    = 1'b0;
        ls_ar_i          = '0;
        if_r_ready_i     = 1'b0;
        ls_r_ready_i     = 1'b0;
        ls_aw_valid_i    = 1'b0;
        ls_aw_i          = '0;
        ls_w_valid_i     = 1'b0;
        ls_w_i           = '0;
        ls_b_ready_i     = 1'b0;
        mem_ar_ready_i   = 1'b0;
        mmio_ar_ready_i  = 1'b0;
        mem_r_valid_i    = 1'b0;
        mem_r_i          = '0;
        mmio_r_valid_i   = 1'b0;
        mmio_r_i         = '0;
        mem_aw_ready_i   = 1'b0;
        mmio_aw_ready_i  = 1'b0;
        mem_w_ready_i    = 1'b0;
        mmio_w_ready_i   = 1'b0;
        mem_b_valid_i    = 1'b0;
        mem_b_i          = '0;
        mmio_b_valid_i   = 1'b0;
        mmio_b_i         = '0;
    endtask

    task automatic check_req(input string name, input xbar_pkg::axi_addr_req_t exp,
                             input xbar_pkg::axi_addr_req_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_w(input string name, input xbar_pkg::axi_w_beat_t exp,
                           input xbar_pkg::axi_w_beat_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_r(input string name, input xbar_pkg::axi_r_beat_t exp,
                           input xbar_pkg::axi_r_beat_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_b(input string name, input xbar_pkg::axi_b_resp_t exp,
                           input xbar_pkg::axi_b_resp_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            value_errs++;
        end
    endtask

    function automatic logic hs_seen(input int ch);
        case (ch)
            CH_AR:   return (if_ar_valid_i & if_ar_ready_o) | (ls_ar_valid_i & ls_ar_ready_o);
            CH_R:    return (if_r_valid_o & if_r_ready_i) | (ls_r_valid_o & ls_r_ready_i);
            CH_AW:   return ls_aw_valid_i & ls_aw_ready_o;
            CH_W:    return ls_w_valid_i & ls_w_ready_o;
            default: return ls_b_valid_o & ls_b_ready_i;
        endcase
    endfunction

    // called at the sample point, returns on the falling edge after the transfer
    task automatic wait_handshake(input string name, input int ch);
        int n;
        n = 0;
        while (!hs_seen(ch) && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!hs_seen(ch)) begin
            $display("%s: no handshake within %0d cycles", name, TIMEOUT);
            timeout_errs++;
        end
        @(negedge clk);
    endtask

    // the other master offers a request to the opposite slave with another id
    task automatic send_ar(input string name, input logic fetch,
                           input xbar_pkg::axi_addr_req_t req);
        xbar_pkg::axi_addr_req_t other;
        logic                    to_mmio;
        other = req;
        other.addr[xbar_pkg::MMIO_SEL_BIT] = ~req.addr[xbar_pkg::MMIO_SEL_BIT];
        other.id = req.id ^ 4'h1;
        to_mmio = req.addr[xbar_pkg::MMIO_SEL_BIT];
        instr_fetching_i = fetch;
        if_ar_i          = fetch ? req : other;
        ls_ar_i          = fetch ? other : req;
        if_ar_valid_i    = 1'b1;
        ls_ar_valid_i    = 1'b1;
        mem_ar_ready_i   = 1'b1;
        mmio_ar_ready_i  = 1'b1;
        #1;
        check_bit({name, " mem_ar_valid"}, ~to_mmio, mem_ar_valid_o);
        check_bit({name, " mmio_ar_valid"}, to_mmio, mmio_ar_valid_o);
        check_req({name, " slv_ar"}, req, slv_ar_o);
        check_bit({name, " unselected ar_ready"}, 1'b0, fetch ? ls_ar_ready_o : if_ar_ready_o);
        wait_handshake({name, " ar"}, CH_AR);
        if_ar_valid_i   = 1'b0;
        ls_ar_valid_i   = 1'b0;
        mem_ar_ready_i  = 1'b0;
        mmio_ar_ready_i = 1'b0;
    endtask

    // both slaves offer a beat, only the latched one may get through
    task automatic return_r(input string name, input logic from_mmio,
                            input xbar_pkg::axi_r_beat_t beat);
        xbar_pkg::axi_r_beat_t other;
        logic                  to_ls;
        other = beat;
        other.data = ~beat.data;
        other.id = beat.id ^ 4'h1;
        to_ls = beat.id[xbar_pkg::ID_LS_BIT];
        mem_r_i        = from_mmio ? other : beat;
        mmio_r_i       = from_mmio ? beat : other;
        mem_r_valid_i  = 1'b1;
        mmio_r_valid_i = 1'b1;
        if_r_ready_i   = 1'b1;
        ls_r_ready_i   = 1'b1;
        #1;
        check_bit({name, " if_r_valid"}, ~to_ls, if_r_valid_o);
        check_bit({name, " ls_r_valid"}, to_ls, ls_r_valid_o);
        check_r({name, " r"}, beat, r_o);
        check_bit({name, " mem_r_ready"}, ~from_mmio, mem_r_ready_o);
        check_bit({name, " mmio_r_ready"}, from_mmio, mmio_r_ready_o);
        wait_handshake({name, " r"}, CH_R);
        mem_r_valid_i  = 1'b0;
        mmio_r_valid_i = 1'b0;
        if_r_ready_i   = 1'b0;
        ls_r_ready_i   = 1'b0;
    endtask

    task automatic test_reset_idle();
        if_r_ready_i = 1'b1;   // master readies must not leak to idle slaves
        ls_r_ready_i = 1'b1;
        ls_b_ready_i = 1'b1;
        #1;
        check_bit("reset_idle slave valids", 1'b0, mem_ar_valid_o | mmio_ar_valid_o
                  | mem_aw_valid_o | mmio_aw_valid_o | mem_w_valid_o | mmio_w_valid_o);
        check_bit("reset_idle slave readies", 1'b0, mem_r_ready_o | mmio_r_ready_o
                  | mem_b_ready_o | mmio_b_ready_o);
        @(negedge clk);
        drive_idle();
    endtask

    task automatic test_if_read_mem();
        xbar_pkg::axi_addr_req_t req;
        xbar_pkg::axi_r_beat_t   beat;
        req = '{addr: 64'h1000_0040, id: 4'h2, len: 8'h00, size: 3'h3, burst: 2'b01};
        send_ar("if_read_mem", 1'b1, req);
        beat = '{data: {$random(seed), $random(seed)}, resp: 2'b00, last: 1'b1, id: 4'h2};
        return_r("if_read_mem", 1'b0, beat);
    endtask

    task automatic test_ls_read_mmio();
        xbar_pkg::axi_addr_req_t req;
        xbar_pkg::axi_r_beat_t   beat;
        req = '{addr: 64'h2000_0010, id: 4'h1, len: 8'h00, size: 3'h2, burst: 2'b01};
        send_ar("ls_read_mmio", 1'b0, req);
        beat = '{data: {$random(seed), $random(seed)}, resp: 2'b00, last: 1'b1, id: 4'h1};
        return_r("ls_read_mmio", 1'b1, beat);
    endtask

    task automatic test_ar_blocked_while_busy();
        xbar_pkg::axi_addr_req_t req;
        xbar_pkg::axi_r_beat_t   beat;
        req = '{addr: 64'h2000_0100, id: 4'h3, len: 8'h01, size: 3'h3, burst: 2'b01};
        send_ar("ar_blocked first", 1'b0, req);
        ls_ar_i = '{addr: 64'h0000_0200, id: 4'h5, len: 8'h00, size: 3'h3, burst: 2'b01};
        ls_ar_valid_i  = 1'b1;
        mem_ar_ready_i = 1'b1;
        repeat (2) begin
            #1;
            check_bit("ar_blocked mem_ar_valid", 1'b0, mem_ar_valid_o);
            check_bit("ar_blocked ls_ar_ready", 1'b0, ls_ar_ready_o);
            @(negedge clk);
        end
        beat = '{data: {$random(seed), $random(seed)}, resp: 2'b00, last: 1'b0, id: 4'h3};
        return_r("ar_blocked beat 0", 1'b1, beat);
        #1;
        check_bit("ar_blocked mid burst", 1'b0, mem_ar_valid_o | ls_ar_ready_o);
        @(negedge clk);
        beat.data = {$random(seed), $random(seed)};
        beat.last = 1'b1;
        return_r("ar_blocked beat 1", 1'b1, beat);
        #1;
        check_bit("ar_released mem_ar_valid", 1'b1, mem_ar_valid_o);
        check_bit("ar_released ls_ar_ready", 1'b1, ls_ar_ready_o);
        wait_handshake("ar_released ar", CH_AR);
        ls_ar_valid_i  = 1'b0;
        mem_ar_ready_i = 1'b0;
        beat = '{data: {$random(seed), $random(seed)}, resp: 2'b00, last: 1'b1, id: 4'h5};
        return_r("ar_released", 1'b0, beat);
    endtask

    task automatic test_ls_write(input string name, input logic to_mmio);
        xbar_pkg::axi_addr_req_t req;
        xbar_pkg::axi_w_beat_t   w;
        xbar_pkg::axi_b_resp_t   b;
        xbar_pkg::axi_b_resp_t   other_b;
        req = '{addr: 64'h0000_0080, id: 4'h6, len: 8'h00, size: 3'h3, burst: 2'b01};
        req.addr[xbar_pkg::MMIO_SEL_BIT] = to_mmio;
        w = '{data: {$random(seed), $random(seed)}, strb: 8'hff, last: 1'b1};
        b = '{resp: 2'b00, id: 4'h6};
        other_b = '{resp: 2'b10, id: 4'h9};
        ls_aw_i         = req;
        ls_aw_valid_i   = 1'b1;
        ls_w_i          = w;
        ls_w_valid_i    = 1'b1;
        mem_aw_ready_i  = 1'b1;
        mmio_aw_ready_i = 1'b1;
        mem_w_ready_i   = 1'b1;
        mmio_w_ready_i  = 1'b1;
        #1;
        check_bit({name, " mem_aw_valid"}, ~to_mmio, mem_aw_valid_o);
        check_bit({name, " mmio_aw_valid"}, to_mmio, mmio_aw_valid_o);
        check_req({name, " slv_aw"}, req, slv_aw_o);
        check_bit({name, " ls_aw_ready"}, 1'b1, ls_aw_ready_o);
        check_bit({name, " early w"}, 1'b0, ls_w_ready_o | mem_w_valid_o | mmio_w_valid_o);
        wait_handshake({name, " aw"}, CH_AW);
        ls_aw_valid_i = 1'b0;
        #1;
        check_bit({name, " mem_w_valid"}, ~to_mmio, mem_w_valid_o);
        check_bit({name, " mmio_w_valid"}, to_mmio, mmio_w_valid_o);
        check_bit({name, " ls_w_ready"}, 1'b1, ls_w_ready_o);
        check_w({name, " slv_w"}, w, slv_w_o);
        wait_handshake({name, " w"}, CH_W);
        ls_w_valid_i   = 1'b0;
        mem_b_i        = to_mmio ? other_b : b;
        mmio_b_i       = to_mmio ? b : other_b;
        mem_b_valid_i  = 1'b1;
        mmio_b_valid_i = 1'b1;
        ls_b_ready_i   = 1'b1;
        #1;
        check_bit({name, " ls_b_valid"}, 1'b1, ls_b_valid_o);
        check_b({name, " b"}, b, ls_b_o);
        check_bit({name, " mem_b_ready"}, ~to_mmio, mem_b_ready_o);
        check_bit({name, " mmio_b_ready"}, to_mmio, mmio_b_ready_o);
        wait_handshake({name, " b"}, CH_B);
        drive_idle();
    endtask

    initial begin
        drive_idle();
        arst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        test_reset_idle();
        test_if_read_mem();
        test_ls_read_mmio();
        test_ar_blocked_while_busy();
        test_ls_write("ls_write_mmio", 1'b1);
        test_ls_write("ls_write_mem", 1'b0);
        $display("errors: value %0d, timeout %0d", value_errs, timeout_errs);
        if (value_errs + timeout_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* dv/xbar_assertions.sv */
`timescale 1ns/10ps

module xbar_assertions (
    input logic clk,
    input logic arst_n_i,
    input logic mem_valid_i,
    input logic mem_ready_i,
    input logic mmio_valid_i,
    input logic mmio_ready_i,
    input logic done_i,         // response handshake that closes the transaction
    input logic busy_i,
    input logic mem_match_i,    // response equals mem payload
    input logic mmio_match_i    // response equals mmio payload
);

    logic addr_hs;
    logic open_q;    // transaction seen at the slave ports
    logic mmio_q;

    assign addr_hs = (mem_valid_i && mem_ready_i) || (mmio_valid_i && mmio_ready_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            open_q <= 1'b0;
            mmio_q <= 1'b0;
        end else if (addr_hs) begin
            open_q <= 1'b1;
            mmio_q <= mmio_valid_i && mmio_ready_i;
        end else if (done_i) begin
            open_q <= 1'b0;
        end
    end

    a_busy_matches: assert property (@(posedge clk) disable iff (!arst_n_i)
        busy_i == open_q)
        else $error("path busy flag disagrees with slave handshakes");

    a_blocked_when_open: assert property (@(posedge clk) disable iff (!arst_n_i)
        open_q |-> !(mem_valid_i || mmio_valid_i))
        else $error("slave address valid high with a transaction open");

    a_resp_from_latched: assert property (@(posedge clk) disable iff (!arst_n_i)
        open_q |-> (mmio_q ? mmio_match_i : mem_match_i))
        else $error("response not taken from the slave that took the address");

endmodule

bind xbar_read_path xbar_assertions i_rd_assertions (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .mem_valid_i  (mem_ar_valid_o),
    .mem_ready_i  (mem_ar_ready_i),
    .mmio_valid_i (mmio_ar_valid_o),
    .mmio_ready_i (mmio_ar_ready_i),
    .done_i       (((if_r_valid_o && if_r_ready_i) || (ls_r_valid_o && ls_r_ready_i))
                   && r_o.last),
    .busy_i       (rd_busy_q),
    .mem_match_i  (r_o == mem_r_i),
    .mmio_match_i (r_o == mmio_r_i)
);

bind xbar_write_path xbar_assertions i_wr_assertions (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .mem_valid_i  (mem_aw_valid_o),
    .mem_ready_i  (mem_aw_ready_i),
    .mmio_valid_i (mmio_aw_valid_o),
    .mmio_ready_i (mmio_aw_ready_i),
    .done_i       (ls_b_valid_o && ls_b_ready_i),
    .busy_i       (wr_busy_q),
    .mem_match_i  (ls_b_o == mem_b_i),
    .mmio_match_i (ls_b_o == mmio_b_i)
);
